// File: hw/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// Data path and register file
`define RV_XLEN      32
`define RV_NUM_REGS  32
`define RV_REG_AW    5

// First fetch address after reset
`define RV_RESET_PC  32'h0000_0000

// One strobe bit per byte lane
`define RV_STRB_W    4

// Instruction field widths
`define RV_OPCODE_W  7
`define RV_FUNCT3_W  3
`define RV_FUNCT7_W  7

`endif

// File: hw/rv_pkg.sv
`include "rv_settings.svh"

package rv_pkg;

  typedef logic [`RV_XLEN-1:0]   word_t;
  typedef logic [`RV_REG_AW-1:0] reg_idx_t;
  typedef logic [`RV_STRB_W-1:0] strb_t;

  // Major opcodes of the supported subset
  typedef enum logic [`RV_OPCODE_W-1:0] {
    OPC_LUI    = 7'b0110111,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_e;

  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_PC_PLUS4,
    RES_IMM
  } res_src_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_JAL,
    BR_JALR
  } br_kind_e;

  typedef enum logic [1:0] {
    MEM_BYTE_SIGNED,
    MEM_BYTE_UNSIGNED,
    MEM_WORD
  } mem_size_e;

endpackage

// File: hw/rv_ctrl_if.sv
`timescale 1ns/1ps

interface rv_ctrl_if;
  import rv_pkg::*;

  // Control decoded from the current instruction
  alu_op_e   alu_op;
  logic      alu_b_imm;
  res_src_e  res_src;
  br_kind_e  br_kind;
  logic      mem_read;
  logic      mem_write;
  mem_size_e mem_size;
  logic      reg_write;
  reg_idx_t  rd;

  // Operands and addresses
  word_t     imm;
  word_t     pc;
  word_t     pc_plus4;
  word_t     rs1_data;
  word_t     rs2_data;

  modport id (
    output alu_op, alu_b_imm, res_src, br_kind, mem_read, mem_write, mem_size,
    output reg_write, rd, imm, pc, pc_plus4, rs1_data, rs2_data
  );

  modport ex (input alu_op, alu_b_imm, br_kind, imm, pc, rs1_data, rs2_data);

  modport wb (
    input res_src, mem_read, mem_write, mem_size, reg_write, rd, imm, pc_plus4,
    input rs2_data
  );

endinterface

// File: hw/rv_stage_pc.sv
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_stage_pc (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          hold,
  input  logic          redirect,
  input  rv_pkg::word_t redirect_target,
  output rv_pkg::word_t pc,
  output rv_pkg::word_t pc_plus4
);
  import rv_pkg::*;

  assign pc_plus4 = pc + word_t'(4);

  // Redirect wins over hold, hold wins over the sequential step
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= `RV_RESET_PC;
    end else if (redirect) begin
      pc <= redirect_target;
    end else if (!hold) begin
      pc <= pc_plus4;
    end
  end

endmodule

// File: hw/rv_regfile.sv
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_regfile (
  input  logic             clk,
  input  logic             rst_n,
  input  rv_pkg::reg_idx_t rs1,
  input  rv_pkg::reg_idx_t rs2,
  output rv_pkg::word_t    rs1_data,
  output rv_pkg::word_t    rs2_data,
  input  logic             we,
  input  rv_pkg::reg_idx_t rd,
  input  rv_pkg::word_t    rd_data
);
  import rv_pkg::*;

  word_t regs [`RV_NUM_REGS];

  // x0 is never written, so it stays at its reset value
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// File: hw/rv_stage_id.sv
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_stage_id (
  input  rv_pkg::word_t    instr,
  input  rv_pkg::word_t    pc,
  input  rv_pkg::word_t    pc_plus4,
  input  rv_pkg::word_t    rs1_data,
  input  rv_pkg::word_t    rs2_data,
  output rv_pkg::reg_idx_t rs1,
  output rv_pkg::reg_idx_t rs2,
  rv_ctrl_if.id            ctrl,
  output logic             is_ebreak,
  output logic             illegal
);
  import rv_pkg::*;

  localparam word_t EBREAK_WORD = 32'h0010_0073;

  opcode_e                 opcode;
  logic [`RV_FUNCT3_W-1:0] funct3;
  logic [`RV_FUNCT7_W-1:0] funct7;
  word_t                   imm_i;
  word_t                   imm_s;
  word_t                   imm_b;
  word_t                   imm_u;
  word_t                   imm_j;
  logic                    valid;

  //------------------------------------------------------------
  // Fields and immediates
  //------------------------------------------------------------

  assign opcode = opcode_e'(instr[`RV_OPCODE_W-1:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Operands pass straight on to execute
  assign ctrl.rd       = instr[11:7];
  assign ctrl.pc       = pc;
  assign ctrl.pc_plus4 = pc_plus4;
  assign ctrl.rs1_data = rs1_data;
  assign ctrl.rs2_data = rs2_data;

  //------------------------------------------------------------
  // Control decode
  //------------------------------------------------------------

  always_comb begin
    ctrl.alu_op    = ALU_ADD;
    ctrl.alu_b_imm = 1'b0;
    ctrl.res_src   = RES_ALU;
    ctrl.br_kind   = BR_NONE;
    ctrl.mem_read  = 1'b0;
    ctrl.mem_write = 1'b0;
    ctrl.mem_size  = MEM_WORD;
    ctrl.reg_write = 1'b0;
    ctrl.imm       = '0;
    valid          = 1'b0;
    is_ebreak      = 1'b0;

    case (opcode)
      OPC_LUI: begin
        ctrl.imm       = imm_u;
        ctrl.res_src   = RES_IMM;
        ctrl.reg_write = 1'b1;
        valid          = 1'b1;
      end
      OPC_OP_IMM, OPC_OP: begin
        ctrl.imm       = imm_i;
        ctrl.alu_b_imm = (opcode == OPC_OP_IMM);
        ctrl.reg_write = 1'b1;
        // Register forms need funct7 zero, except SUB
        valid = (opcode == OPC_OP_IMM) || (funct7 == 7'b0000000);
        case (funct3)
          3'b000: begin
            if ((opcode == OPC_OP) && (funct7 == 7'b0100000)) begin
              ctrl.alu_op = ALU_SUB;
              valid       = 1'b1;
            end
          end
          3'b111: ctrl.alu_op = ALU_AND;
          3'b110: ctrl.alu_op = ALU_OR;
          3'b100: ctrl.alu_op = ALU_XOR;
          3'b010: ctrl.alu_op = ALU_SLT;
          default: valid = 1'b0;
        endcase
      end
      OPC_LOAD: begin
        ctrl.imm       = imm_i;
        ctrl.alu_b_imm = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.res_src   = RES_MEM;
        ctrl.reg_write = 1'b1;
        valid          = 1'b1;
        case (funct3)
          3'b000:  ctrl.mem_size = MEM_BYTE_SIGNED;
          3'b100:  ctrl.mem_size = MEM_BYTE_UNSIGNED;
          3'b010:  ctrl.mem_size = MEM_WORD;
          default: valid = 1'b0;
        endcase
      end
      OPC_STORE: begin
        ctrl.imm       = imm_s;
        ctrl.alu_b_imm = 1'b1;
        ctrl.mem_write = 1'b1;
        valid          = 1'b1;
        case (funct3)
          3'b000:  ctrl.mem_size = MEM_BYTE_UNSIGNED;
          3'b010:  ctrl.mem_size = MEM_WORD;
          default: valid = 1'b0;
        endcase
      end
      OPC_BRANCH: begin
        ctrl.imm = imm_b;
        valid    = 1'b1;
        case (funct3)
          3'b000:  ctrl.br_kind = BR_EQ;
          3'b001:  ctrl.br_kind = BR_NE;
          3'b100:  ctrl.br_kind = BR_LT;
          3'b101:  ctrl.br_kind = BR_GE;
          default: valid = 1'b0;
        endcase
      end
      OPC_JAL: begin
        ctrl.imm       = imm_j;
        ctrl.br_kind   = BR_JAL;
        ctrl.res_src   = RES_PC_PLUS4;
        ctrl.reg_write = 1'b1;
        valid          = 1'b1;
      end
      OPC_JALR: begin
        ctrl.imm       = imm_i;
        ctrl.br_kind   = BR_JALR;
        ctrl.res_src   = RES_PC_PLUS4;
        ctrl.reg_write = 1'b1;
        valid          = (funct3 == 3'b000);
      end
      OPC_SYSTEM: begin
        is_ebreak = (instr == EBREAK_WORD);
        valid     = is_ebreak;
      end
      default: valid = 1'b0;
    endcase

    // A halting instruction has no side effects at all
    if (!valid || is_ebreak) begin
      ctrl.reg_write = 1'b0;
      ctrl.mem_read  = 1'b0;
      ctrl.mem_write = 1'b0;
      ctrl.br_kind   = BR_NONE;
    end
  end

  assign illegal = !valid;

endmodule

// File: hw/rv_stage_ex.sv
`timescale 1ns/1ps

module rv_stage_ex (
  rv_ctrl_if.ex         ctrl,
  output rv_pkg::word_t alu_result,
  output logic          redirect,
  output rv_pkg::word_t redirect_target
);
  import rv_pkg::*;

  word_t alu_b;
  logic  rs_eq;
  logic  rs_lt;
  word_t pc_target;
  word_t jalr_sum;

  //------------------------------------------------------------
  // ALU
  //------------------------------------------------------------

  assign alu_b = ctrl.alu_b_imm ? ctrl.imm : ctrl.rs2_data;

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD: alu_result = ctrl.rs1_data + alu_b;
      ALU_SUB: alu_result = ctrl.rs1_data - alu_b;
      ALU_AND: alu_result = ctrl.rs1_data & alu_b;
      ALU_OR:  alu_result = ctrl.rs1_data | alu_b;
      ALU_XOR: alu_result = ctrl.rs1_data ^ alu_b;
      ALU_SLT: alu_result = word_t'($signed(ctrl.rs1_data) < $signed(alu_b));
      default: alu_result = '0;
    endcase
  end

  //------------------------------------------------------------
  // Branches and jumps
  //------------------------------------------------------------

  // Branch compares always use both registers
  assign rs_eq = (ctrl.rs1_data == ctrl.rs2_data);
  assign rs_lt = ($signed(ctrl.rs1_data) < $signed(ctrl.rs2_data));

  always_comb begin
    case (ctrl.br_kind)
      BR_EQ:   redirect = rs_eq;
      BR_NE:   redirect = !rs_eq;
      BR_LT:   redirect = rs_lt;
      BR_GE:   redirect = !rs_lt;
      BR_JAL:  redirect = 1'b1;
      BR_JALR: redirect = 1'b1;
      default: redirect = 1'b0;
    endcase
  end

  assign pc_target = ctrl.pc + ctrl.imm;
  assign jalr_sum  = ctrl.rs1_data + ctrl.imm;

  // JALR drops bit 0 of the sum
  assign redirect_target = (ctrl.br_kind == BR_JALR) ? {jalr_sum[31:1], 1'b0} : pc_target;

endmodule

// File: hw/rv_stage_mem.sv
`timescale 1ns/1ps

module rv_stage_mem (
  rv_ctrl_if.wb         ctrl,
  input  rv_pkg::word_t addr,
  input  rv_pkg::word_t dmem_rdata,
  output rv_pkg::word_t wdata,
  output rv_pkg::strb_t wstrb,
  output rv_pkg::word_t load_data
);
  import rv_pkg::*;

  logic [1:0] byte_sel;
  logic [7:0] load_byte;

  assign byte_sel = addr[1:0];

  //------------------------------------------------------------
  // Store lanes
  //------------------------------------------------------------

  always_comb begin
    if (ctrl.mem_size == MEM_WORD) begin
      wdata = ctrl.rs2_data;
      wstrb = '1;
    end else begin
      // Same byte in every lane, strobe picks the target
      wdata = {4{ctrl.rs2_data[7:0]}};
      wstrb = strb_t'(1) << byte_sel;
    end
    if (!ctrl.mem_write) begin
      wstrb = '0;
    end
  end

  //------------------------------------------------------------
  // Load extraction
  //------------------------------------------------------------

  assign load_byte = dmem_rdata[8*byte_sel +: 8];

  always_comb begin
    case (ctrl.mem_size)
      MEM_BYTE_SIGNED:   load_data = {{24{load_byte[7]}}, load_byte};
      MEM_BYTE_UNSIGNED: load_data = {24'b0, load_byte};
      default:           load_data = dmem_rdata;
    endcase
  end

endmodule

// File: hw/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic          clk,
  input  logic          rst_n,

  // Instruction fetch
  output logic          imem_arvalid,
  output rv_pkg::word_t imem_araddr,
  input  rv_pkg::word_t imem_rdata,

  // Data reads
  output logic          dmem_ren,
  output rv_pkg::word_t dmem_raddr,
  input  rv_pkg::word_t dmem_rdata,

  // Data writes
  output logic          dmem_we,
  output rv_pkg::word_t dmem_waddr,
  output rv_pkg::word_t dmem_wdata,
  output rv_pkg::strb_t dmem_wstrb,

  output logic          ebreak,
  output logic          trap
);
  import rv_pkg::*;

  rv_ctrl_if ctrl ();

  word_t    pc;
  word_t    pc_plus4;
  reg_idx_t rs1;
  reg_idx_t rs2;
  word_t    rs1_data;
  word_t    rs2_data;
  logic     is_ebreak;
  logic     illegal;
  word_t    alu_result;
  logic     redirect;
  word_t    redirect_target;
  word_t    load_data;
  word_t    wb_data;
  logic     rf_we;
  logic     halt;
  logic     halt_now;

  //------------------------------------------------------------
  // Stages
  //------------------------------------------------------------

  rv_stage_pc stage_pc (
    .clk            (clk),
    .rst_n          (rst_n),
    .hold           (halt || halt_now),
    .redirect       (redirect && !halt),
    .redirect_target(redirect_target),
    .pc             (pc),
    .pc_plus4       (pc_plus4)
  );

  rv_regfile regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1     (rs1),
    .rs2     (rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .we      (rf_we),
    .rd      (ctrl.rd),
    .rd_data (wb_data)
  );

  rv_stage_id stage_id (
    .instr    (imem_rdata),
    .pc       (pc),
    .pc_plus4 (pc_plus4),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1      (rs1),
    .rs2      (rs2),
    .ctrl     (ctrl),
    .is_ebreak(is_ebreak),
    .illegal  (illegal)
  );

  rv_stage_ex stage_ex (
    .ctrl           (ctrl),
    .alu_result     (alu_result),
    .redirect       (redirect),
    .redirect_target(redirect_target)
  );

  rv_stage_mem stage_mem (
    .ctrl      (ctrl),
    .addr      (alu_result),
    .dmem_rdata(dmem_rdata),
    .wdata     (dmem_wdata),
    .wstrb     (dmem_wstrb),
    .load_data (load_data)
  );

  //------------------------------------------------------------
  // Memory ports and write-back
  //------------------------------------------------------------

  assign imem_arvalid = !halt;
  assign imem_araddr  = pc;

  assign dmem_ren   = ctrl.mem_read && !halt;
  assign dmem_raddr = alu_result;
  assign dmem_we    = ctrl.mem_write && !halt;
  assign dmem_waddr = alu_result;

  always_comb begin
    case (ctrl.res_src)
      RES_MEM:      wb_data = load_data;
      RES_PC_PLUS4: wb_data = ctrl.pc_plus4;
      RES_IMM:      wb_data = ctrl.imm;
      default:      wb_data = alu_result;
    endcase
  end

  assign rf_we = ctrl.reg_write && !halt;

  //------------------------------------------------------------
  // Halt
  //------------------------------------------------------------

  // Fetched data is meaningless once halted
  assign halt_now = (is_ebreak || illegal) && !halt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      halt   <= 1'b0;
      ebreak <= 1'b0;
      trap   <= 1'b0;
    end else begin
      halt   <= halt || halt_now;
      ebreak <= ebreak || (is_ebreak && !halt);
      trap   <= trap || (illegal && !halt);
    end
  end

endmodule

// File: verification/rv_clk_gen.sv
`timescale 1ns/1ps

module rv_clk_gen (
  output logic clk,
  output logic rst_n
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // Reset held low for the first three rising edges
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: verification/rv_core_tb.sv
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_core_tb;
  import rv_pkg::*;

  typedef struct packed {
    logic  st;
    logic  ld;
    word_t addr;
    word_t data;
    strb_t strb;
    logic  eb;
    logic  tr;
  } step_t;

  logic   clk;
  logic   gen_rst_n;
  logic   rst_req;
  logic   core_rst_n;
  logic   imem_arvalid;
  word_t  imem_araddr;
  word_t  imem_rdata;
  logic   dmem_ren;
  word_t  dmem_raddr;
  word_t  dmem_rdata;
  logic   dmem_we;
  word_t  dmem_waddr;
  word_t  dmem_wdata;
  strb_t  dmem_wstrb;
  logic   ebreak;
  logic   trap;

  word_t  rom [256];
  word_t  ram [256];
  word_t  prog [$];
  word_t  prog_a [$];
  word_t  prog_b [$];
  integer seed;
  int     limit_ns;
  int     phases_done;

  // Reference state
  word_t  ref_pc;
  word_t  ref_regs [32];
  word_t  ref_mem [256];
  logic   ref_halted;
  logic   idle;
  int     post_cnt;
  step_t  cur;
  logic   exp_eb;
  logic   exp_tr;

  rv_clk_gen clk_gen (.clk(clk), .rst_n(gen_rst_n));

  assign core_rst_n = gen_rst_n && !rst_req;

  rv_core dut (
    .clk         (clk),
    .rst_n       (core_rst_n),
    .imem_arvalid(imem_arvalid),
    .imem_araddr (imem_araddr),
    .imem_rdata  (imem_rdata),
    .dmem_ren    (dmem_ren),
    .dmem_raddr  (dmem_raddr),
    .dmem_rdata  (dmem_rdata),
    .dmem_we     (dmem_we),
    .dmem_waddr  (dmem_waddr),
    .dmem_wdata  (dmem_wdata),
    .dmem_wstrb  (dmem_wstrb),
    .ebreak      (ebreak),
    .trap        (trap)
  );

  //------------------------------------------------------------
  // Memory models
  //------------------------------------------------------------

  function automatic word_t fill_word(logic [7:0] idx);
    return ({24'h0, idx} * 32'h9E37_79B1) ^ 32'hC3A5_0F1E;
  endfunction

  assign imem_rdata = rom[imem_araddr[9:2]];
  assign dmem_rdata = ram[dmem_raddr[9:2]];

  always @(posedge clk) begin
    if (!core_rst_n) begin
      for (int i = 0; i < 256; i++) begin
        ram[i[7:0]] <= fill_word(i[7:0]);
      end
    end else if (dmem_we) begin
      for (int k = 0; k < 4; k++) begin
        if (dmem_wstrb[k[1:0]]) begin
          ram[dmem_waddr[9:2]][8*k +: 8] <= dmem_wdata[8*k +: 8];
        end
      end
    end
  end

  //------------------------------------------------------------
  // Instruction encoders and programs
  //------------------------------------------------------------

  function automatic word_t enc_i(logic [6:0] opc, logic [2:0] f3, reg_idx_t rd,
                                  reg_idx_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [2:0] f3, reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic word_t enc_s(logic [2:0] f3, reg_idx_t rs2, reg_idx_t rs1,
                                  logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic word_t enc_b(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2,
                                  logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic word_t enc_u(reg_idx_t rd, logic [19:0] imm);
    return {imm, rd, 7'h37};
  endfunction

  function automatic word_t enc_j(reg_idx_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6F};
  endfunction

  task automatic emit(word_t w);
    prog.push_back(w);
  endtask

  task automatic build_prog_a();
    logic [31:0] r;
    logic [3:0]  kind;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [11:0] imm;
    int          pos;
    // x0 write, then store it back
    emit(enc_i(7'h13, 3'b000, 5'd0, 5'd0, 12'h123));
    emit(enc_s(3'b010, 5'd0, 5'd0, 12'h0FC));
    for (int i = 0; i < 24; i++) begin
      r = $random(seed);
      kind = r[3:0];
      if (kind > 4'd11) kind = kind - 4'd8;
      rd  = {2'b00, r[6:4]};
      rs1 = {2'b00, r[9:7]};
      rs2 = {2'b00, r[12:10]};
      imm = r[24:13];
      case (kind)
        4'd0:  emit(enc_i(7'h13, 3'b000, rd, rs1, imm));
        4'd1:  emit(enc_i(7'h13, 3'b111, rd, rs1, imm));
        4'd2:  emit(enc_i(7'h13, 3'b110, rd, rs1, imm));
        4'd3:  emit(enc_i(7'h13, 3'b100, rd, rs1, imm));
        4'd4:  emit(enc_i(7'h13, 3'b010, rd, rs1, imm));
        4'd5:  emit(enc_r(7'h00, rs2, rs1, 3'b000, rd));
        4'd6:  emit(enc_r(7'h20, rs2, rs1, 3'b000, rd));
        4'd7:  emit(enc_r(7'h00, rs2, rs1, 3'b111, rd));
        4'd8:  emit(enc_r(7'h00, rs2, rs1, 3'b110, rd));
        4'd9:  emit(enc_r(7'h00, rs2, rs1, 3'b100, rd));
        4'd10: emit(enc_r(7'h00, rs2, rs1, 3'b010, rd));
        default: emit(enc_u(rd, r[31:12]));
      endcase
      emit(enc_s(3'b010, rd, 5'd0, 12'(256 + 4*i)));
    end

    // Byte stores and loads on a mixed-sign word
    emit(enc_u(5'd10, 20'h80F7E));
    emit(enc_i(7'h13, 3'b000, 5'd10, 5'd10, 12'h001));
    emit(enc_s(3'b010, 5'd10, 5'd0, 12'h210));
    for (int k = 0; k < 4; k++) begin
      emit(enc_i(7'h13, 3'b000, 5'd11, 5'd0, 12'(156 + 17*k)));
      emit(enc_s(3'b000, 5'd11, 5'd0, 12'(512 + k)));
      emit(enc_i(7'h03, 3'b000, 5'd12, 5'd0, 12'(528 + k)));
      emit(enc_s(3'b010, 5'd12, 5'd0, 12'(544 + 8*k)));
      emit(enc_i(7'h03, 3'b100, 5'd13, 5'd0, 12'(528 + k)));
      emit(enc_s(3'b010, 5'd13, 5'd0, 12'(548 + 8*k)));
    end
    emit(enc_i(7'h03, 3'b010, 5'd14, 5'd0, 12'h200));
    emit(enc_s(3'b010, 5'd14, 5'd0, 12'h260));

    // Branch pairs, a taken branch skips its marker store
    emit(enc_i(7'h13, 3'b000, 5'd1, 5'd0, 12'h005));
    emit(enc_i(7'h13, 3'b000, 5'd2, 5'd0, 12'h005));
    emit(enc_i(7'h13, 3'b000, 5'd3, 5'd0, 12'hFFD));
    emit(enc_b(3'b000, 5'd1, 5'd2, 13'd8));
    emit(enc_s(3'b010, 5'd1, 5'd0, 12'h300));
    emit(enc_b(3'b000, 5'd1, 5'd3, 13'd8));
    emit(enc_s(3'b010, 5'd1, 5'd0, 12'h304));
    emit(enc_b(3'b001, 5'd1, 5'd3, 13'd8));
    emit(enc_s(3'b010, 5'd1, 5'd0, 12'h308));
    emit(enc_b(3'b001, 5'd1, 5'd2, 13'd8));
    emit(enc_s(3'b010, 5'd1, 5'd0, 12'h30C));
    emit(enc_b(3'b100, 5'd3, 5'd1, 13'd8));
    emit(enc_s(3'b010, 5'd1, 5'd0, 12'h310));
    emit(enc_b(3'b100, 5'd1, 5'd3, 13'd8));
    emit(enc_s(3'b010, 5'd1, 5'd0, 12'h314));
    emit(enc_b(3'b101, 5'd1, 5'd3, 13'd8));
    emit(enc_s(3'b010, 5'd1, 5'd0, 12'h318));
    emit(enc_b(3'b101, 5'd3, 5'd1, 13'd8));
    emit(enc_s(3'b010, 5'd1, 5'd0, 12'h31C));

    // Jumps with link registers stored afterwards
    emit(enc_j(5'd5, 21'd8));
    emit(enc_s(3'b010, 5'd1, 5'd0, 12'h3F0));
    emit(enc_s(3'b010, 5'd5, 5'd0, 12'h340));
    pos = prog.size();
    emit(enc_i(7'h13, 3'b000, 5'd6, 5'd0, 12'((pos + 3)*4 + 1)));
    emit(enc_i(7'h67, 3'b000, 5'd7, 5'd6, 12'h000));
    emit(enc_s(3'b010, 5'd1, 5'd0, 12'h3F4));
    emit(enc_s(3'b010, 5'd7, 5'd0, 12'h344));
    emit(enc_s(3'b010, 5'd6, 5'd0, 12'h348));

    emit(32'h0010_0073);
    emit(enc_s(3'b010, 5'd1, 5'd0, 12'h3F8));
  endtask

  task automatic build_prog_b();
    emit(enc_i(7'h13, 3'b000, 5'd1, 5'd0, 12'h007));
    emit(enc_s(3'b010, 5'd1, 5'd0, 12'h380));
    emit(32'hFFFF_FFFF);
    emit(enc_s(3'b010, 5'd1, 5'd0, 12'h384));
  endtask

  task automatic load_rom(input word_t img [$]);
    for (int i = 0; i < 256; i++) begin
      rom[i[7:0]] = (i < img.size()) ? img[i] : '0;
    end
  endtask

  //------------------------------------------------------------
  // Reference model
  //------------------------------------------------------------

  function automatic step_t ref_step();
    step_t       r;
    word_t       instr;
    word_t       a;
    word_t       b;
    word_t       op_b;
    word_t       imm_i;
    word_t       imm_s;
    word_t       imm_b;
    word_t       imm_j;
    word_t       val;
    word_t       nxt;
    word_t       addr;
    word_t       w;
    logic        wr;
    logic        take;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [6:0]  opc;
    reg_idx_t    rd;
    instr = rom[ref_pc[9:2]];
    r     = '0;
    wr    = 1'b0;
    take  = 1'b0;
    val   = '0;
    nxt   = ref_pc + 32'd4;
    opc   = instr[6:0];
    f3    = instr[14:12];
    f7    = instr[31:25];
    rd    = instr[11:7];
    a     = ref_regs[instr[19:15]];
    b     = ref_regs[instr[24:20]];
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    case (opc)
      7'h37: begin
        wr  = 1'b1;
        val = {instr[31:12], 12'h000};
      end
      7'h13, 7'h33: begin
        op_b = (opc == 7'h13) ? imm_i : b;
        wr   = 1'b1;
        if ((opc == 7'h33) && (f7 == 7'h20) && (f3 == 3'b000)) begin
          val = a - op_b;
        end else if ((opc == 7'h33) && (f7 != 7'h00)) begin
          r.tr = 1'b1;
        end else begin
          case (f3)
            3'b000:  val = a + op_b;
            3'b111:  val = a & op_b;
            3'b110:  val = a | op_b;
            3'b100:  val = a ^ op_b;
            3'b010:  val = {31'b0, $signed(a) < $signed(op_b)};
            default: r.tr = 1'b1;
          endcase
        end
      end
      7'h03: begin
        addr   = a + imm_i;
        r.ld   = 1'b1;
        r.addr = addr;
        w      = ref_mem[addr[9:2]] >> {addr[1:0], 3'b000};
        wr     = 1'b1;
        case (f3)
          3'b000:  val = {{24{w[7]}}, w[7:0]};
          3'b100:  val = {24'h0, w[7:0]};
          3'b010:  val = ref_mem[addr[9:2]];
          default: r.tr = 1'b1;
        endcase
      end
      7'h23: begin
        addr   = a + imm_s;
        r.addr = addr;
        if (f3 == 3'b010) begin
          r.st   = 1'b1;
          r.data = b;
          r.strb = 4'hF;
        end else if (f3 == 3'b000) begin
          r.st   = 1'b1;
          r.data = {4{b[7:0]}};
          r.strb = 4'b0001 << addr[1:0];
        end else begin
          r.tr = 1'b1;
        end
      end
      7'h63: begin
        case (f3)
          3'b000:  take = (a == b);
          3'b001:  take = (a != b);
          3'b100:  take = ($signed(a) < $signed(b));
          3'b101:  take = ($signed(a) >= $signed(b));
          default: r.tr = 1'b1;
        endcase
        if (take) nxt = ref_pc + imm_b;
      end
      7'h6F: begin
        wr  = 1'b1;
        val = ref_pc + 32'd4;
        nxt = ref_pc + imm_j;
      end
      7'h67: begin
        if (f3 == 3'b000) begin
          wr  = 1'b1;
          val = ref_pc + 32'd4;
          nxt = (a + imm_i) & ~32'd1;
        end else begin
          r.tr = 1'b1;
        end
      end
      7'h73: begin
        if (instr == 32'h0010_0073) r.eb = 1'b1;
        else r.tr = 1'b1;
      end
      default: r.tr = 1'b1;
    endcase

    // Halting instructions leave no trace
    if (r.eb || r.tr) begin
      wr   = 1'b0;
      r.st = 1'b0;
      r.ld = 1'b0;
      nxt  = ref_pc;
    end
    if (r.st) begin
      for (int k = 0; k < 4; k++) begin
        if (r.strb[k[1:0]]) ref_mem[r.addr[9:2]][8*k +: 8] = r.data[8*k +: 8];
      end
    end
    if (wr && (rd != 5'd0)) ref_regs[rd] = val;
    ref_pc = nxt;
    return r;
  endfunction

  //------------------------------------------------------------
  // Checks
  //------------------------------------------------------------

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1);
  endtask

  task automatic check_fetch(word_t got, word_t exp);
    if (got !== exp) begin
      report_failure($sformatf("MISMATCH imem_araddr: got %h expected %h", got, exp));
    end
  endtask

  task automatic check_load(logic ren, word_t addr, step_t exp);
    if (ren !== exp.ld) begin
      report_failure($sformatf("MISMATCH dmem_ren: got %h expected %h", ren, exp.ld));
    end
    if (exp.ld && (addr !== exp.addr)) begin
      report_failure($sformatf("MISMATCH dmem_raddr: got %h expected %h", addr, exp.addr));
    end
  endtask

  task automatic check_store(word_t addr, word_t data, strb_t strb, step_t exp);
    if (addr !== exp.addr) begin
      report_failure($sformatf("MISMATCH dmem_waddr: got %h expected %h", addr, exp.addr));
    end
    if (data !== exp.data) begin
      report_failure($sformatf("MISMATCH dmem_wdata: got %h expected %h", data, exp.data));
    end
    if (strb !== exp.strb) begin
      report_failure($sformatf("MISMATCH dmem_wstrb: got %h expected %h", strb, exp.strb));
    end
  endtask

  task automatic check_halt(logic eb, logic tr, logic eb_exp, logic tr_exp);
    if (eb !== eb_exp) begin
      report_failure($sformatf("MISMATCH ebreak: got %h expected %h", eb, eb_exp));
    end
    if (tr !== tr_exp) begin
      report_failure($sformatf("MISMATCH trap: got %h expected %h", tr, tr_exp));
    end
  endtask

  // Compare once per cycle in the middle of the clock period
  always @(negedge clk) begin
    if (!core_rst_n) begin
      ref_pc     = `RV_RESET_PC;
      ref_halted = 1'b0;
      idle       = 1'b0;
      post_cnt   = 0;
      for (int i = 0; i < 32; i++) begin
        ref_regs[i[4:0]] = '0;
      end
      for (int i = 0; i < 256; i++) begin
        ref_mem[i[7:0]] = fill_word(i[7:0]);
      end
    end else if (!idle) begin
      if (!ref_halted) begin
        if (imem_arvalid !== 1'b1) report_failure("Fetch stopped before any halt");
        check_fetch(imem_araddr, ref_pc);
        check_halt(ebreak, trap, 1'b0, 1'b0);
        cur = ref_step();
        check_load(dmem_ren, dmem_raddr, cur);
        if (cur.st) begin
          if (dmem_we !== 1'b1) report_failure("Expected store did not happen");
          check_store(dmem_waddr, dmem_wdata, dmem_wstrb, cur);
        end else if (dmem_we !== 1'b0) begin
          report_failure("Store happened where none was expected");
        end
        if (cur.eb || cur.tr) begin
          ref_halted = 1'b1;
          exp_eb     = cur.eb;
          exp_tr     = cur.tr;
        end
      end else begin
        check_halt(ebreak, trap, exp_eb, exp_tr);
        if (imem_arvalid !== 1'b0) report_failure("Fetch still active after halt");
        check_fetch(imem_araddr, ref_pc);
        if (dmem_we !== 1'b0) report_failure("Store happened after halt");
        if (dmem_ren !== 1'b0) report_failure("Load happened after halt");
        post_cnt++;
        if (post_cnt == 4) begin
          idle = 1'b1;
          phases_done++;
        end
      end
    end
  end

  //------------------------------------------------------------
  // Sequencing and watchdog
  //------------------------------------------------------------

  initial begin
    seed        = 32'h49e34250;
    rst_req     = 1'b0;
    phases_done = 0;
    limit_ns    = 0;
    build_prog_a();
    prog_a = prog;
    prog.delete();
    build_prog_b();
    prog_b = prog;
    limit_ns = (prog_a.size() + prog_b.size() + 100) * 10;
    load_rom(prog_a);
    wait (phases_done == 1);

    // Second program runs after a fresh reset
    load_rom(prog_b);
    @(posedge clk);
    rst_req <= 1'b1;
    repeat (3) @(posedge clk);
    rst_req <= 1'b0;
    wait (phases_done == 2);
    @(posedge clk);
    $display("Done: no errors");
    $finish;
  end

  initial begin
    wait (limit_ns > 0);
    #(limit_ns);
    report_failure("Timeout: the programs did not reach their halt in time");
  end

endmodule

// File: rv_core.f
+incdir+hw
hw/rv_pkg.sv
hw/rv_ctrl_if.sv
hw/rv_stage_pc.sv
hw/rv_regfile.sv
hw/rv_stage_id.sv
hw/rv_stage_ex.sv
hw/rv_stage_mem.sv
hw/rv_core.sv
verification/rv_clk_gen.sv
verification/rv_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f rv_core.f --top-module rv_core_tb -o rv_core_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/rv_core_sim 2>&1)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Done: no errors"; then
  exit 0
fi
echo "Pass message not found"
exit 1
